// File: filelist.f
src/periph_pkg.sv
src/io_decode.sv
src/ps2_receiver.sv
src/ppi_ports.sv
src/peripherals.sv
dv/tb_peripherals.sv

// File: dv/tb_peripherals.sv
/*
 * Directed testbench for the peripheral block. Clock and reset,
 * LFSR stimulus, CPU bus and PS/2 frame tasks, and one task per test.
 */
`default_nettype none

module tb_peripherals;

    logic        clock;
    logic        reset;
    logic [19:0] address;
    logic [7:0]  data;
    logic        io_read_n;
    logic        io_write_n;
    logic        address_enable_n;
    logic        interrupt_acknowledge_n;
    logic        ps2_clock;
    logic        ps2_data;
    logic [7:0]  port_c;

    logic [7:0]  data_o;
    logic        data_from_chipset;
    logic        interrupt;
    logic        ps2_busy;
    logic [7:0]  port_b;
    logic        dma_cs_n;
    logic        pic_cs_n;
    logic        pit_cs_n;
    logic        dma_page_cs_n;

    logic [16:0] lfsr_state;
    int          error_count;
    int          test_count;

    peripherals peripherals_i (
        .clock                     (clock),
        .reset                     (reset),
        .address_i                 (address),
        .data_i                    (data),
        .io_read_n_i               (io_read_n),
        .io_write_n_i              (io_write_n),
        .address_enable_n_i        (address_enable_n),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n),
        .data_o                    (data_o),
        .data_from_chipset_o       (data_from_chipset),
        .interrupt_o               (interrupt),
        .ps2_clock_i               (ps2_clock),
        .ps2_data_i                (ps2_data),
        .port_c_i                  (port_c),
        .ps2_busy_o                (ps2_busy),
        .port_b_o                  (port_b),
        .dma_chip_select_n_o       (dma_cs_n),
        .pic_chip_select_n_o       (pic_cs_n),
        .pit_chip_select_n_o       (pit_cs_n),
        .dma_page_chip_select_n_o  (dma_page_cs_n)
    );

    always #4 clock = ~clock;

    // x^17 + x^14 + 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [19:0] io_address(input int group, input logic [4:0] offset);
        return {12'h000, 3'(group), offset};
    endfunction

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch %s: expected %0h, actual %0h", test_name, expected, actual);
        error_count++;
    endtask

    task automatic bus_write(input logic [19:0] addr, input logic [7:0] value);
        @(negedge clock);
        address          = addr;
        data             = value;
        address_enable_n = 1'b0;
        io_write_n       = 1'b0;
        @(negedge clock);
        io_write_n       = 1'b1;
        address_enable_n = 1'b1;
    endtask

    // Read data is combinational, sampled in the middle of the low phase
    task automatic bus_read(input logic [19:0] addr, output logic [7:0] value,
                            output logic claimed);
        @(negedge clock);
        address          = addr;
        address_enable_n = 1'b0;
        io_read_n        = 1'b0;
        #2;
        value   = data_o;
        claimed = data_from_chipset;
        @(negedge clock);
        io_read_n        = 1'b1;
        address_enable_n = 1'b1;
    endtask

    // Start, data LSB first, odd parity, stop; 20 cycles per half period
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            repeat (20) @(negedge clock);
            ps2_clock = 1'b0;
            repeat (20) @(negedge clock);
            ps2_clock = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic wait_interrupt(input logic level, input int limit, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clock);
            if (interrupt === level) seen = 1'b1;
        end
    endtask

    task automatic test_reset_state();
        test_count++;
        @(negedge clock);
        #2;
        if (port_b !== 8'h00) report_mismatch("reset port_b", 8'h00, port_b);
        if (interrupt !== 1'b0) report_mismatch("reset interrupt", 1'b0, interrupt);
        if (data_from_chipset !== 1'b0) report_mismatch("reset data_from_chipset", 1'b0,
                                                        data_from_chipset);
        if (ps2_busy !== 1'b1) report_mismatch("reset ps2_busy", 1'b1, ps2_busy);
        if ({dma_page_cs_n, pit_cs_n, pic_cs_n, dma_cs_n} !== 4'hf) begin
            report_mismatch("reset selects", 4'hf, {dma_page_cs_n, pit_cs_n, pic_cs_n, dma_cs_n});
        end
    endtask

    task automatic test_decode();
        logic [19:0] addr;
        logic        in_range;
        logic [3:0]  expected;
        logic [3:0]  actual;
        test_count++;
        for (int i = 0; i < 40; i++) begin
            addr = 20'(random_bits(20));
            if (random_bits(1)) addr[19:10] = '0;
            if (random_bits(1)) addr[9:8] = '0;
            for (int aen = 0; aen < 2; aen++) begin
                @(negedge clock);
                address          = addr;
                address_enable_n = aen[0];
                #2;
                in_range    = (aen == 0) && (addr[19:8] == 12'h000);
                expected[0] = ~(in_range && addr[7:5] == 3'd0);
                expected[1] = ~(in_range && addr[7:5] == 3'd1);
                expected[2] = ~(in_range && addr[7:5] == 3'd2);
                expected[3] = ~(in_range && addr[7:5] == 3'd4);
                actual      = {dma_page_cs_n, pit_cs_n, pic_cs_n, dma_cs_n};
                if (actual !== expected) report_mismatch("decode", expected, actual);
            end
        end
        @(negedge clock);
        address_enable_n = 1'b1;
    endtask

    task automatic test_port_b();
        logic [7:0]  value;
        logic [7:0]  read_value;
        logic        claimed;
        logic [19:0] addr;
        test_count++;
        for (int i = 0; i < 6; i++) begin
            value    = 8'(random_bits(8));
            value[7] = 1'b0;
            // Port B mirrors through the group every four bytes
            addr = io_address(periph_pkg::GROUP_PPI, {3'(random_bits(3)), 2'b01});
            bus_write(addr, value);
            bus_read(addr, read_value, claimed);
            if (read_value !== value) report_mismatch("port_b read", value, read_value);
            if (claimed !== 1'b1) report_mismatch("port_b claimed", 1'b1, claimed);
            if (port_b !== value) report_mismatch("port_b output", value, port_b);
            if (ps2_busy !== ~value[6]) report_mismatch("port_b busy", ~value[6], ps2_busy);
        end
        bus_read(io_address(periph_pkg::GROUP_PPI, 5'd3), read_value, claimed);
        if (read_value !== 8'h00) report_mismatch("control word read", 8'h00, read_value);
        if (claimed !== 1'b1) report_mismatch("control word claimed", 1'b1, claimed);
        @(negedge clock);
        port_c = 8'(random_bits(8));
        bus_read(io_address(periph_pkg::GROUP_PPI, 5'd2), read_value, claimed);
        if (read_value !== port_c) report_mismatch("port_c read", port_c, read_value);
    endtask

    task automatic test_good_frame();
        logic [7:0] code;
        logic [7:0] read_value;
        logic       claimed;
        logic       seen;
        test_count++;
        // Keyboard clock enabled so busy can only come from the interrupt
        bus_write(io_address(periph_pkg::GROUP_PPI, 5'd1), 8'h40);
        @(negedge clock);
        if (ps2_busy !== 1'b0) report_mismatch("idle busy", 1'b0, ps2_busy);
        code = 8'(random_bits(8));
        send_ps2_frame(code, 1'b0);
        wait_interrupt(1'b1, 100, seen);
        if (!seen) begin
            $display("Keyboard interrupt never rose after a good frame");
            error_count++;
        end
        bus_read(io_address(periph_pkg::GROUP_PPI, 5'd0), read_value, claimed);
        if (read_value !== code) report_mismatch("good frame keycode", code, read_value);
        if (ps2_busy !== 1'b1) report_mismatch("good frame busy", 1'b1, ps2_busy);
        bus_write(io_address(periph_pkg::GROUP_PPI, 5'd1), 8'hc0);
        wait_interrupt(1'b0, 10, seen);
        if (!seen) begin
            $display("Keyboard interrupt stayed high while port B clear bit was set");
            error_count++;
        end
        bus_read(io_address(periph_pkg::GROUP_PPI, 5'd0), read_value, claimed);
        if (read_value !== 8'h00) report_mismatch("cleared keycode", 8'h00, read_value);
        bus_write(io_address(periph_pkg::GROUP_PPI, 5'd1), 8'h40);
    endtask

    task automatic test_bad_frame();
        logic [7:0] read_value;
        logic       claimed;
        logic       seen;
        test_count++;
        send_ps2_frame(8'(random_bits(8)), 1'b1);
        // Two frame lengths of device clock
        wait_interrupt(1'b1, 2 * 11 * 40, seen);
        if (seen) begin
            $display("Keyboard interrupt rose after a frame with bad parity");
            error_count++;
        end
        bus_read(io_address(periph_pkg::GROUP_PPI, 5'd0), read_value, claimed);
        if (read_value !== 8'h00) report_mismatch("bad frame keycode", 8'h00, read_value);
    endtask

    task automatic test_unclaimed_read();
        logic [19:0] addr_list [7];
        logic [7:0]  read_value;
        logic        claimed;
        test_count++;
        addr_list[0] = io_address(periph_pkg::GROUP_PIC, 5'd0);
        addr_list[1] = io_address(periph_pkg::GROUP_PIT, 5'd3);
        addr_list[2] = io_address(periph_pkg::GROUP_DMA, 5'd8);
        addr_list[3] = io_address(periph_pkg::GROUP_PAGE, 5'd1);
        // PPI group with page or high bits set
        addr_list[4] = 20'h00160;
        addr_list[5] = 20'h00361;
        addr_list[6] = 20'h40062;
        for (int i = 0; i < 7; i++) begin
            bus_read(addr_list[i], read_value, claimed);
            if (claimed !== 1'b0) report_mismatch("unclaimed read claimed", 1'b0, claimed);
            if (read_value !== 8'h00) report_mismatch("unclaimed read data", 8'h00, read_value);
        end
    endtask

    initial begin
        clock                   = 1'b0;
        reset                   = 1'b1;
        address                 = '0;
        data                    = '0;
        io_read_n               = 1'b1;
        io_write_n              = 1'b1;
        address_enable_n        = 1'b1;
        interrupt_acknowledge_n = 1'b1;
        ps2_clock               = 1'b1;
        ps2_data                = 1'b1;
        port_c                  = '0;
        lfsr_state              = 17'd80766;
        error_count             = 0;
        test_count              = 0;

        repeat (8) @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_decode();
        test_port_b();
        test_good_frame();
        test_bad_frame();
        test_unclaimed_read();

        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/peripherals.sv
/*
 * Peripheral block top. Connects the I/O decoder, PS/2 receiver
 * and PPI ports, and drives the CPU read bus.
 */
`default_nettype none

module peripherals (
    input  wire logic                          clock,
    input  wire logic                          reset,
    // CPU bus
    input  wire logic [periph_pkg::ADDR_W-1:0] address_i,
    input  wire logic [periph_pkg::DATA_W-1:0] data_i,
    input  wire logic                          io_read_n_i,
    input  wire logic                          io_write_n_i,
    input  wire logic                          address_enable_n_i,
    input  wire logic                          interrupt_acknowledge_n_i,
    output logic      [periph_pkg::DATA_W-1:0] data_o,
    output logic                               data_from_chipset_o,
    output logic                               interrupt_o,
    // Keyboard and ports
    input  wire logic                          ps2_clock_i,
    input  wire logic                          ps2_data_i,
    input  wire logic [periph_pkg::DATA_W-1:0] port_c_i,
    output logic                               ps2_busy_o,
    output logic      [periph_pkg::DATA_W-1:0] port_b_o,
    // Selects for outside chips
    output logic                               dma_chip_select_n_o,
    output logic                               pic_chip_select_n_o,
    output logic                               pit_chip_select_n_o,
    output logic                               dma_page_chip_select_n_o
);

    periph_pkg::io_addr_u io_address;

    logic [periph_pkg::GROUP_COUNT-1:0] chip_select_n;
    logic                               ppi_chip_select_n;
    logic [periph_pkg::DATA_W-1:0]      keycode;
    logic                               kbd_irq;
    logic [periph_pkg::DATA_W-1:0]      ppi_read_data;

    // Interrupt acknowledge has no consumer without the PIC

    assign io_address.raw = address_i;

    io_decode io_decode_i (
        .address_i          (io_address),
        .address_enable_n_i (address_enable_n_i),
        .chip_select_n_o    (chip_select_n)
    );

    assign dma_chip_select_n_o      = chip_select_n[periph_pkg::GROUP_DMA];
    assign pic_chip_select_n_o      = chip_select_n[periph_pkg::GROUP_PIC];
    assign pit_chip_select_n_o      = chip_select_n[periph_pkg::GROUP_PIT];
    assign dma_page_chip_select_n_o = chip_select_n[periph_pkg::GROUP_PAGE];
    assign ppi_chip_select_n        = chip_select_n[periph_pkg::GROUP_PPI];

    ps2_receiver ps2_receiver_i (
        .clock       (clock),
        .reset       (reset),
        .ps2_clock_i (ps2_clock_i),
        .ps2_data_i  (ps2_data_i),
        .clear_i     (port_b_o[periph_pkg::PORTB_KBD_CLEAR]),
        .keycode_o   (keycode),
        .irq_o       (kbd_irq)
    );

    ppi_ports ppi_ports_i (
        .clock           (clock),
        .reset           (reset),
        .chip_select_n_i (ppi_chip_select_n),
        .io_write_n_i    (io_write_n_i),
        .offset_i        (io_address.fields.offset[1:0]),
        .data_i          (data_i),
        .port_a_i        (keycode),
        .port_c_i        (port_c_i),
        .read_data_o     (ppi_read_data),
        .port_b_o        (port_b_o)
    );

    assign interrupt_o = kbd_irq;
    assign ps2_busy_o  = kbd_irq | ~port_b_o[periph_pkg::PORTB_KBD_CLK_EN_N];

    // Read bus, PPI is the only chipset source left
    always_comb begin
        if (~ppi_chip_select_n && ~io_read_n_i) begin
            data_from_chipset_o = 1'b1;
            data_o              = ppi_read_data;
        end else begin
            data_from_chipset_o = 1'b0;
            data_o              = '0;
        end
    end

endmodule

`default_nettype wire

// File: src/ppi_ports.sv
/*
 * PPI-style port block. Port A reads the keycode, port B is a
 * read/write control register, port C reads external inputs and
 * the control word location reads zero.
 */
`default_nettype none

module ppi_ports (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          chip_select_n_i,
    input  wire logic                          io_write_n_i,
    input  wire logic      [1:0]               offset_i,
    input  wire logic      [periph_pkg::DATA_W-1:0] data_i,
    input  wire logic      [periph_pkg::DATA_W-1:0] port_a_i,
    input  wire logic      [periph_pkg::DATA_W-1:0] port_c_i,
    output logic           [periph_pkg::DATA_W-1:0] read_data_o,
    output logic           [periph_pkg::DATA_W-1:0] port_b_o
);

    logic write_port_b;

    // Held strobe just rewrites the same value
    assign write_port_b = ~chip_select_n_i
                        & ~io_write_n_i
                        & (offset_i == periph_pkg::PPI_OFS_PORT_B);

    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_o <= '0;
        end else if (write_port_b) begin
            port_b_o <= data_i;
        end
    end

    // Directions are fixed, control word is a dead location
    always_comb begin
        case (offset_i)
            periph_pkg::PPI_OFS_PORT_A: read_data_o = port_a_i;
            periph_pkg::PPI_OFS_PORT_B: read_data_o = port_b_o;
            periph_pkg::PPI_OFS_PORT_C: read_data_o = port_c_i;
            periph_pkg::PPI_OFS_CTRL:   read_data_o = '0;
            default:                    read_data_o = '0;
        endcase
    end

    // Any write cycle into the group must carry defined data
    a_write_data_known: assert property (
        @(posedge clock) disable iff (reset)
        (~chip_select_n_i & ~io_write_n_i) |-> ~$isunknown(data_i)
    ) else $error("PPI write with unknown data");

endmodule

`default_nettype wire

// File: src/ps2_receiver.sv
/*
 * PS/2 keyboard receiver. Synchronizes the device lines, shifts in
 * eleven-bit frames, checks start, odd parity and stop, and holds
 * the keycode and interrupt until cleared.
 */
`default_nettype none

module ps2_receiver (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         ps2_clock_i,
    input  wire logic                         ps2_data_i,
    input  wire logic                         clear_i,
    output logic      [periph_pkg::DATA_W-1:0] keycode_o,
    output logic                              irq_o
);

    logic ps2_clock_meta;
    logic ps2_clock_sync;
    logic ps2_clock_prev;
    logic ps2_data_meta;
    logic ps2_data_sync;
    logic ps2_fall;

    logic [$clog2(periph_pkg::PS2_FRAME_BITS)-1:0]     bit_count;
    logic [$clog2(periph_pkg::PS2_TIMEOUT_CYCLES)-1:0] idle_count;
    logic [periph_pkg::PS2_FRAME_BITS-2:0]             shift;

    logic frame_end;
    logic frame_ok;
    logic timed_out;

    // Two-stage synchronizer on both lines, plus an edge history flop
    always_ff @(posedge clock) begin
        if (reset) begin
            ps2_clock_meta <= 1'b1;
            ps2_clock_sync <= 1'b1;
            ps2_clock_prev <= 1'b1;
            ps2_data_meta  <= 1'b1;
            ps2_data_sync  <= 1'b1;
        end else begin
            ps2_clock_meta <= ps2_clock_i;
            ps2_clock_sync <= ps2_clock_meta;
            ps2_clock_prev <= ps2_clock_sync;
            ps2_data_meta  <= ps2_data_i;
            ps2_data_sync  <= ps2_data_meta;
        end
    end

    assign ps2_fall = ps2_clock_prev & ~ps2_clock_sync;

    // Stop bit arrives live with the last fall
    assign frame_end = ps2_fall
                     & (bit_count == $bits(bit_count)'(periph_pkg::PS2_FRAME_BITS - 1));
    assign frame_ok  = frame_end & ~shift[0] & ps2_data_sync & (^shift[9:1]);

    assign timed_out = (bit_count != '0)
                     & (idle_count == $bits(idle_count)'(periph_pkg::PS2_TIMEOUT_CYCLES - 1));

    // Bits come LSB first, start bit ends up in shift[0]
    always_ff @(posedge clock) begin
        if (ps2_fall) begin
            shift <= {ps2_data_sync, shift[periph_pkg::PS2_FRAME_BITS-2:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            bit_count  <= '0;
            idle_count <= '0;
            keycode_o  <= '0;
            irq_o      <= 1'b0;
        end else begin
            if (ps2_fall) begin
                idle_count <= '0;
                if (frame_end) begin
                    bit_count <= '0;
                end else begin
                    bit_count <= bit_count + 1'b1;
                end
            end else if (timed_out) begin
                // Partial frame dropped
                bit_count  <= '0;
                idle_count <= '0;
            end else if (bit_count != '0) begin
                idle_count <= idle_count + 1'b1;
            end

            if (frame_ok) begin
                keycode_o <= shift[8:1];
                irq_o     <= 1'b1;
            end
        end
    end

    // Clear from port B drops the interrupt by the next cycle
    a_clear_drops_irq: assert property (
        @(posedge clock) disable iff (reset)
        clear_i |=> ~irq_o
    ) else $error("Keyboard interrupt still high after clear");

    // A pending keycode only moves when another good frame lands
    a_keycode_held: assert property (
        @(posedge clock) disable iff (reset)
        (irq_o & ~clear_i & ~frame_ok) |=> $stable(keycode_o)
    ) else $error("Keycode changed while interrupt pending");

endmodule

`default_nettype wire

// File: src/io_decode.sv
/*
 * I/O address decoder. Splits the low I/O space into eight groups
 * and drives one active-low select per group.
 */
`default_nettype none

module io_decode (
    input  periph_pkg::io_addr_u               address_i,
    input  wire logic                          address_enable_n_i,
    output logic [periph_pkg::GROUP_COUNT-1:0] chip_select_n_o
);

    logic io_space;

    // Only the first 1 KB of I/O space with page bits clear is decoded
    assign io_space = ~address_enable_n_i
                    & (address_i.fields.high == '0)
                    & (address_i.fields.page == '0);

    always_comb begin
        chip_select_n_o = '1;
        if (io_space) begin
            chip_select_n_o[address_i.fields.group] = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/periph_pkg.sv
/*
 * Shared constants for the XT peripheral block. Holds the address map,
 * the I/O address union, PPI port offsets, port B bit positions and
 * the PS/2 frame constants.
 */
`default_nettype none

package periph_pkg;

    // Bus widths
    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    // Low I/O space is cut into eight 32-byte groups
    localparam int GROUP_COUNT = 8;

    localparam int GROUP_DMA  = 0;
    localparam int GROUP_PIC  = 1;
    localparam int GROUP_PIT  = 2;
    localparam int GROUP_PPI  = 3;
    localparam int GROUP_PAGE = 4;

    // One I/O address seen flat or split into decode fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [9:0] high;    // Zero for decoded I/O
            logic [1:0] page;    // Zero for decoded I/O
            logic [2:0] group;
            logic [4:0] offset;
        } fields;
    } io_addr_u;

    // PPI offsets, only the low two bits are decoded
    localparam logic [1:0] PPI_OFS_PORT_A = 2'd0;
    localparam logic [1:0] PPI_OFS_PORT_B = 2'd1;
    localparam logic [1:0] PPI_OFS_PORT_C = 2'd2;
    localparam logic [1:0] PPI_OFS_CTRL   = 2'd3;

    // Port B control bits
    localparam int PORTB_TIMER_GATE   = 0;
    localparam int PORTB_SPEAKER_DATA = 1;
    localparam int PORTB_KBD_CLK_EN_N = 6;
    localparam int PORTB_KBD_CLEAR    = 7;

    // Start, eight data bits, odd parity, stop
    localparam int PS2_FRAME_BITS = 11;

    // Longest gap between device clock falls before a partial frame is dropped
    localparam int PS2_TIMEOUT_CYCLES = 1000;

endpackage

`default_nettype wire
